/* src/viaPkg.sv */
/*
	Shared types for the 6522-style interface adapter.
	Holds the register map, the register bus struct, the interrupt source
	struct, the port pin bundle and the IFR bit positions.
	Modules import it inside their bodies.
*/

package viaPkg;

	typedef logic [7:0]  viaByte_t;
	typedef logic [3:0]  regSel_t;
	typedef logic [15:0] viaCount_t;

	// Register map, RS0..RS15
	typedef enum logic [3:0] {
		regOrb, regOra, regDdrb, regDdra,
		regT1cl, regT1ch, regT1ll, regT1lh,
		regT2cl, regT2ch,
		regSr, regAcr, regPcr, regIfr, regIer, regOraNh
	} regAddr_e;

	// One host transfer, fanned out to every peer
	typedef struct packed {
		logic     sel;
		logic     rnw;
		regSel_t  rs;
		viaByte_t wdata;
	} viaBus_t;

	// Set pulses, MSB first so bit n matches IFR bit n
	typedef struct packed {
		logic t1;
		logic t2;
		logic cb1;
		logic cb2;
		logic sr;
		logic ca1;
		logic ca2;
	} irqSrc_t;

	typedef struct packed {
		viaByte_t outVal;
		viaByte_t oe;
	} pinBus_t;

	localparam int flagCa2 = 0;
	localparam int flagCa1 = 1;
	localparam int flagSr  = 2;
	localparam int flagCb2 = 3;
	localparam int flagCb1 = 4;
	localparam int flagT2  = 5;
	localparam int flagT1  = 6;

endpackage

/* src/edgeDetect.sv */
/*
	Single-polarity edge detector for a control or port pin.
	The pin is registered once, and the previous sample only moves on
	enabled cycles, so an edge is reported on the next enabled cycle.
*/

`timescale 1ns/1ps

module edgeDetect #(
	parameter bit risingEdge = 1'b1
) (
	input  logic clk,
	input  logic nRESET,
	input  logic en,
	input  logic pin,
	output logic edgeSeen
);

	logic pinQ;
	logic prevQ;

	always_ff @(posedge clk) begin
		pinQ <= pin;
		// Track the pin during reset so no false edge shows up afterwards
		if (!nRESET || en) begin
			prevQ <= pinQ;
		end
	end

	assign edgeSeen = en & (risingEdge ? (pinQ & ~prevQ) : (~pinQ & prevQ));

endmodule

/* src/viaPorts.sv */
/*
	Parallel ports A and B with their direction registers, plus PCR.
	Drives the pin output values and enables, mixes pin readback per DDR
	and generates the CA2/CB2 level, handshake and pulse outputs.
*/

`timescale 1ns/1ps

module viaPorts (
	input  logic             clk,
	input  logic             nRESET,
	input  logic             clkEn,
	input  viaPkg::viaBus_t  bus,
	input  viaPkg::viaByte_t paIn,
	input  viaPkg::viaByte_t pbIn,
	input  logic             pb7Timer,
	input  logic             pb7Sel,
	input  logic             ca1Set,
	input  logic             cb1Set,
	output viaPkg::pinBus_t  paPins,
	output viaPkg::pinBus_t  pbPins,
	output logic             ca2Out,
	output logic             ca2Oe,
	output logic             cb2Out,
	output logic             cb2Oe,
	output viaPkg::viaByte_t pcr,
	output viaPkg::viaByte_t rdata
);

	import viaPkg::*;

	viaByte_t ora;
	viaByte_t orb;
	viaByte_t ddra;
	viaByte_t ddrb;
	viaByte_t pbOut;
	logic     wrEn;
	logic     oraAccess;
	logic     orbAccess;
	logic     ca2Q;
	logic     cb2Q;

	// Output bits come from the OR, input bits from the pins
	function automatic viaByte_t mixPins(input viaByte_t outVal, input viaByte_t dir,
		input viaByte_t pins);
		return (outVal & dir) | (pins & ~dir);
	endfunction

	// mode is the 3-bit PCR field of CA2 or CB2
	function automatic logic hsNext(input logic cur, input logic [2:0] mode,
		input logic access, input logic ctlEdge);
		if (!mode[2] || mode[1]) begin
			return 1'b1;
		end
		if (access) begin
			return 1'b0;
		end
		// Pulse mode releases after one enabled cycle
		if (mode[0] || ctlEdge) begin
			return 1'b1;
		end
		return cur;
	endfunction

	assign wrEn      = clkEn & bus.sel & ~bus.rnw;
	assign oraAccess = clkEn & bus.sel & (bus.rs == regOra);
	assign orbAccess = clkEn & bus.sel & (bus.rs == regOrb);

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			ddra <= '0;
			ddrb <= '0;
			pcr  <= '0;
			ca2Q <= 1'b1;
			cb2Q <= 1'b1;
		end else begin
			if (wrEn) begin
				case (bus.rs)
					regDdra: ddra <= bus.wdata;
					regDdrb: ddrb <= bus.wdata;
					regPcr:  pcr  <= bus.wdata;
					default: ;
				endcase
			end
			if (clkEn) begin
				ca2Q <= hsNext(ca2Q, pcr[3:1], oraAccess, ca1Set);
				cb2Q <= hsNext(cb2Q, pcr[7:5], orbAccess, cb1Set);
			end
		end
	end

	// Output registers
	always_ff @(posedge clk) begin
		if (wrEn && (bus.rs == regOra || bus.rs == regOraNh)) begin
			ora <= bus.wdata;
		end
		if (wrEn && bus.rs == regOrb) begin
			orb <= bus.wdata;
		end
	end

	assign pbOut  = {pb7Sel ? pb7Timer : orb[7], orb[6:0]};
	assign paPins = '{outVal: ora, oe: ddra};
	assign pbPins = '{outVal: pbOut, oe: ddrb};

	// Level mode drives the PCR bit straight out
	assign ca2Oe  = pcr[3];
	assign ca2Out = pcr[2] ? pcr[1] : ca2Q;
	assign cb2Oe  = pcr[7];
	assign cb2Out = pcr[6] ? pcr[5] : cb2Q;

	always_comb begin
		case (bus.rs)
			regOra, regOraNh: rdata = mixPins(ora, ddra, paIn);
			regOrb:           rdata = mixPins(pbOut, ddrb, pbIn);
			regDdra:          rdata = ddra;
			regDdrb:          rdata = ddrb;
			regPcr:           rdata = pcr;
			default:          rdata = '0;
		endcase
	end

	// Pins stay released through reset
	resetReleasesPins: assert property (@(posedge clk)
		!nRESET ##1 !nRESET |-> (paPins.oe == '0) && (pbPins.oe == '0) && !ca2Oe && !cb2Oe)
		else $error("Output enable high during reset");

endmodule

/* src/viaTimers.sv */
/*
	Interval timers T1 and T2 with ACR.
	T1 reloads from its latch in free-run and one-shot modes and can drive
	PB7. T2 counts clock enables or PB6 falling edges. Both emit one-cycle
	set pulses for the interrupt flags.
*/

`timescale 1ns/1ps

module viaTimers (
	input  logic             clk,
	input  logic             nRESET,
	input  logic             clkEn,
	input  viaPkg::viaBus_t  bus,
	input  logic             pb6Fall,
	output logic             t1Set,
	output logic             t2Set,
	output logic             pb7Timer,
	output viaPkg::viaByte_t acr,
	output viaPkg::viaByte_t rdata
);

	import viaPkg::*;

	viaCount_t t1Count;
	viaCount_t t1Latch;
	viaCount_t t2Count;
	viaByte_t  t2LatchLo;
	logic      t1Armed;
	logic      t2Armed;
	logic      pb7Q;
	logic      wrEn;
	logic      t1Load;
	logic      t2Load;
	logic      t1Fire;
	logic      t2Step;

	assign wrEn   = clkEn & bus.sel & ~bus.rnw;
	assign t1Load = wrEn & (bus.rs == regT1ch);
	assign t2Load = wrEn & (bus.rs == regT2ch);

	// T1 reload happens on the enabled cycle after zero
	assign t1Fire = clkEn & ~t1Load & (t1Count == '0);
	assign t1Set  = t1Fire & (acr[6] | t1Armed);

	// ACR bit 5 switches T2 to PB6 pulse counting
	assign t2Step = clkEn & ~t2Load & (acr[5] ? pb6Fall : 1'b1);
	assign t2Set  = t2Step & t2Armed & (t2Count == '0);

	assign pb7Timer = pb7Q;

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			acr       <= '0;
			t1Count   <= '0;
			t1Latch   <= '0;
			t2Count   <= '0;
			t2LatchLo <= '0;
			t1Armed   <= 1'b0;
			t2Armed   <= 1'b0;
			pb7Q      <= 1'b1;
		end else begin
			if (wrEn) begin
				case (bus.rs)
					regT1cl, regT1ll: t1Latch[7:0]  <= bus.wdata;
					regT1ch, regT1lh: t1Latch[15:8] <= bus.wdata;
					regT2cl:          t2LatchLo     <= bus.wdata;
					regAcr:           acr           <= bus.wdata;
					default: ;
				endcase
			end

			if (t1Load) begin
				t1Count <= {bus.wdata, t1Latch[7:0]};
				t1Armed <= 1'b1;
				pb7Q    <= 1'b0;
			end else if (t1Fire) begin
				t1Count <= t1Latch;
				t1Armed <= 1'b0;
				// Square wave in free-run, single low pulse in one-shot
				if (acr[6]) begin
					pb7Q <= ~pb7Q;
				end else if (t1Armed) begin
					pb7Q <= 1'b1;
				end
			end else if (clkEn) begin
				t1Count <= t1Count - 1'b1;
			end

			if (t2Load) begin
				t2Count <= {bus.wdata, t2LatchLo};
				t2Armed <= 1'b1;
			end else if (t2Step) begin
				// T2 wraps past zero and keeps counting
				t2Count <= t2Count - 1'b1;
				if (t2Count == '0) begin
					t2Armed <= 1'b0;
				end
			end
		end
	end

	always_comb begin
		case (bus.rs)
			regT1cl: rdata = t1Count[7:0];
			regT1ch: rdata = t1Count[15:8];
			regT1ll: rdata = t1Latch[7:0];
			regT1lh: rdata = t1Latch[15:8];
			regT2cl: rdata = t2Count[7:0];
			regT2ch: rdata = t2Count[15:8];
			regAcr:  rdata = acr;
			default: rdata = '0;
		endcase
	end

	// A nonzero latch puts the counter back above zero after a reload
	t1SetIsPulse: assert property (@(posedge clk) disable iff (!nRESET)
		t1Set && (t1Latch != '0) |=> !t1Set)
		else $error("T1 set pulse longer than one cycle");

endmodule

/* src/viaInterrupts.sv */
/*
	Interrupt flag and enable registers.
	Flags are set by timer and edge pulses, cleared by IFR writes and by the
	timer and port accesses, and gated by IER onto the active-low request.
*/

`timescale 1ns/1ps

module viaInterrupts (
	input  logic             clk,
	input  logic             nRESET,
	input  logic             clkEn,
	input  viaPkg::viaBus_t  bus,
	input  viaPkg::irqSrc_t  src,
	input  viaPkg::viaByte_t pcr,
	output logic             nIrq,
	output viaPkg::viaByte_t rdata
);

	import viaPkg::*;

	logic [6:0] ifr;
	logic [6:0] ier;
	logic [6:0] setVec;
	logic [6:0] clrVec;
	logic       access;
	logic       wrEn;
	logic       rdEn;
	logic       ierWrite;
	logic       caIndep;
	logic       cbIndep;

	assign access   = clkEn & bus.sel;
	assign wrEn     = access & ~bus.rnw;
	assign rdEn     = access & bus.rnw;
	assign ierWrite = wrEn & (bus.rs == regIer);

	// Independent input modes keep CA2/CB2 flags across port accesses
	assign caIndep = ~pcr[3] & pcr[1];
	assign cbIndep = ~pcr[7] & pcr[5];

	always_comb begin
		setVec          = '0;
		setVec[flagCa2] = src.ca2;
		setVec[flagCa1] = src.ca1;
		setVec[flagSr]  = src.sr;
		setVec[flagCb2] = src.cb2;
		setVec[flagCb1] = src.cb1;
		setVec[flagT2]  = src.t2;
		setVec[flagT1]  = src.t1;

		clrVec = '0;
		if (wrEn && bus.rs == regIfr) begin
			clrVec = bus.wdata[6:0];
		end
		if ((rdEn && bus.rs == regT1cl) || (wrEn && bus.rs == regT1ch)) begin
			clrVec[flagT1] = 1'b1;
		end
		if ((rdEn && bus.rs == regT2cl) || (wrEn && bus.rs == regT2ch)) begin
			clrVec[flagT2] = 1'b1;
		end
		if (access && bus.rs == regOra) begin
			clrVec[flagCa1] = 1'b1;
			clrVec[flagCa2] = ~caIndep;
		end
		if (access && bus.rs == regOrb) begin
			clrVec[flagCb1] = 1'b1;
			clrVec[flagCb2] = ~cbIndep;
		end
	end

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			ifr <= '0;
			ier <= '0;
		end else begin
			// A set flag ignores new edges while the chip is selected
			ifr <= (ifr & ~clrVec) | (setVec & ~(ifr & {7{bus.sel}}));
			if (ierWrite) begin
				ier <= bus.wdata[7] ? (ier | bus.wdata[6:0]) : (ier & ~bus.wdata[6:0]);
			end
		end
	end

	assign nIrq = ~|(ifr & ier);

	always_comb begin
		case (bus.rs)
			regIfr:  rdata = {~nIrq, ifr};
			regIer:  rdata = {1'b1, ier};
			default: rdata = '0;
		endcase
	end

	// An enabled source raises the request on the following cycle
	enabledSetRaisesIrq: assert property (@(posedge clk) disable iff (!nRESET)
		nRESET && !ierWrite && |(setVec & ier & ~ifr) |=> !nIrq)
		else $error("Enabled interrupt did not assert nIrq");

endmodule

/* src/via6522.sv */
/*
	Top level of the 6522-style interface adapter.
	Builds the register bus from the chip selects, fans it out to the port,
	timer and interrupt blocks, muxes read data back by RS and wires the
	control line and PB6 edge detectors.
*/

`timescale 1ns/1ps

module via6522 (
	input  logic             clk,
	input  logic             nRESET,
	input  logic             clkEn,
	input  logic             cs1,
	input  logic             nCs2,
	input  logic             rnw,
	input  viaPkg::regSel_t  rs,
	input  viaPkg::viaByte_t dataIn,
	output viaPkg::viaByte_t dataOut,
	output logic             dataOe,
	input  viaPkg::viaByte_t paIn,
	input  viaPkg::viaByte_t pbIn,
	output viaPkg::pinBus_t  paPins,
	output viaPkg::pinBus_t  pbPins,
	input  logic             ca1,
	input  logic             ca2In,
	input  logic             cb1In,
	input  logic             cb2In,
	output logic             ca2Out,
	output logic             ca2Oe,
	output logic             cb2Out,
	output logic             cb2Oe,
	output logic             nIrq
);

	import viaPkg::*;

	viaBus_t    bus;
	irqSrc_t    src;
	viaByte_t   pcr;
	viaByte_t   acr;
	viaByte_t   portsRdata;
	viaByte_t   timersRdata;
	viaByte_t   irqRdata;
	logic       pb7Timer;
	logic       t1Set;
	logic       t2Set;
	logic       pb6Fall;
	logic [3:0] ctlPins;
	logic [3:0] ctlPolarity;
	logic [3:0] ctlRise;
	logic [3:0] ctlFall;
	logic [3:0] ctlEdge;

	assign bus    = '{sel: cs1 & ~nCs2, rnw: rnw, rs: rs, wdata: dataIn};
	assign dataOe = bus.sel & bus.rnw;

	always_comb begin
		case (bus.rs)
			regOrb, regOra, regDdrb, regDdra, regPcr, regOraNh: dataOut = portsRdata;
			regT1cl, regT1ch, regT1ll, regT1lh: dataOut = timersRdata;
			regT2cl, regT2ch, regAcr:           dataOut = timersRdata;
			regIfr, regIer:                     dataOut = irqRdata;
			// No shift register
			regSr:   dataOut = '0;
			default: dataOut = '0;
		endcase
	end

	// Order CA1, CA2, CB1, CB2 with their PCR polarity bits
	assign ctlPins     = {cb2In, cb1In, ca2In, ca1};
	assign ctlPolarity = {pcr[6], pcr[4], pcr[2], pcr[0]};

	for (genvar i = 0; i < 4; i++) begin : gCtlEdge
		edgeDetect #(.risingEdge(1'b1)) riseDet (
			.clk(clk), .nRESET(nRESET), .en(clkEn), .pin(ctlPins[i]), .edgeSeen(ctlRise[i])
		);
		edgeDetect #(.risingEdge(1'b0)) fallDet (
			.clk(clk), .nRESET(nRESET), .en(clkEn), .pin(ctlPins[i]), .edgeSeen(ctlFall[i])
		);
		assign ctlEdge[i] = ctlPolarity[i] ? ctlRise[i] : ctlFall[i];
	end

	edgeDetect #(.risingEdge(1'b0)) pb6Det (
		.clk(clk), .nRESET(nRESET), .en(clkEn), .pin(pbIn[6]), .edgeSeen(pb6Fall)
	);

	// CA2/CB2 only interrupt in their input modes
	assign src = '{t1: t1Set, t2: t2Set, cb1: ctlEdge[2], cb2: ctlEdge[3] & ~pcr[7],
		sr: 1'b0, ca1: ctlEdge[0], ca2: ctlEdge[1] & ~pcr[3]};

	viaPorts ports0 (
		.clk(clk), .nRESET(nRESET), .clkEn(clkEn), .bus(bus),
		.paIn(paIn), .pbIn(pbIn), .pb7Timer(pb7Timer), .pb7Sel(acr[7]),
		.ca1Set(src.ca1), .cb1Set(src.cb1), .paPins(paPins), .pbPins(pbPins),
		.ca2Out(ca2Out), .ca2Oe(ca2Oe), .cb2Out(cb2Out), .cb2Oe(cb2Oe),
		.pcr(pcr), .rdata(portsRdata)
	);

	viaTimers timers0 (
		.clk(clk), .nRESET(nRESET), .clkEn(clkEn), .bus(bus), .pb6Fall(pb6Fall),
		.t1Set(t1Set), .t2Set(t2Set), .pb7Timer(pb7Timer), .acr(acr), .rdata(timersRdata)
	);

	viaInterrupts irq0 (
		.clk(clk), .nRESET(nRESET), .clkEn(clkEn), .bus(bus), .src(src), .pcr(pcr),
		.nIrq(nIrq), .rdata(irqRdata)
	);

endmodule

/* bench/viaModel.svh */
/*
	Cycle model of the interface adapter for the testbench.
	Holds the stimulus, output and state structs. modelStep advances the
	state at each rising clk from the applied inputs, and predictOutputs
	gives the expected pins, read data and nIrq for the current inputs.
*/

`ifndef VIA_MODEL_SVH
`define VIA_MODEL_SVH

typedef struct packed {
	logic     clkEn;
	logic     cs1;
	logic     nCs2;
	logic     rnw;
	regSel_t  rs;
	viaByte_t dataIn;
	viaByte_t paIn;
	viaByte_t pbIn;
	logic     ca1;
	logic     ca2In;
	logic     cb1In;
	logic     cb2In;
} stim_t;

typedef struct packed {
	viaByte_t dataOut;
	logic     dataOe;
	pinBus_t  paPins;
	pinBus_t  pbPins;
	logic     ca2Out;
	logic     ca2Oe;
	logic     cb2Out;
	logic     cb2Oe;
	logic     nIrq;
} viaOut_t;

// Pin samples are ordered CA1, CA2, CB1, CB2, PB6 from bit 0
typedef struct packed {
	viaByte_t   ora;
	viaByte_t   orb;
	viaByte_t   ddra;
	viaByte_t   ddrb;
	viaByte_t   pcr;
	viaByte_t   acr;
	viaCount_t  t1Cnt;
	viaCount_t  t1Lat;
	viaCount_t  t2Cnt;
	viaByte_t   t2LatLo;
	logic       t1Armed;
	logic       t2Armed;
	logic       pb7;
	logic       ca2Hs;
	logic       cb2Hs;
	logic [6:0] ifr;
	logic [6:0] ier;
	logic [4:0] pinQ;
	logic [4:0] prevQ;
} viaState_t;

viaState_t model;

// Driven bits read the output register, the rest read the pins
function automatic viaByte_t portRead(input viaByte_t outVal, input viaByte_t dir,
	input viaByte_t pins);
	viaByte_t v;
	for (int i = 0; i < 8; i++) begin
		v[i] = dir[i] ? outVal[i] : pins[i];
	end
	return v;
endfunction

// CA2/CB2 handshake line, mode is the 3-bit PCR field
function automatic logic handshakeLevel(input logic cur, input logic [2:0] mode,
	input logic portAccess, input logic ctlEdge);
	case (mode)
		3'b100:  return portAccess ? 1'b0 : (ctlEdge ? 1'b1 : cur);
		3'b101:  return !portAccess;
		default: return 1'b1;
	endcase
endfunction

task automatic modelStep(input logic inReset, input stim_t s);
	viaState_t  n;
	logic       sel;
	logic       wr;
	logic       rd;
	logic [4:0] rise;
	logic [4:0] fall;
	logic [3:0] pol;
	logic [3:0] act;
	logic       t1Load;
	logic       t2Load;
	logic [6:0] setF;
	logic [6:0] clrF;
	n = model;
	n.pinQ = {s.pbIn[6], s.cb2In, s.cb1In, s.ca2In, s.ca1};
	if (inReset) begin
		n.prevQ   = model.pinQ;
		n.ddra    = '0;
		n.ddrb    = '0;
		n.pcr     = '0;
		n.acr     = '0;
		n.t1Cnt   = '0;
		n.t1Lat   = '0;
		n.t2Cnt   = '0;
		n.t2LatLo = '0;
		n.t1Armed = 1'b0;
		n.t2Armed = 1'b0;
		n.pb7     = 1'b1;
		n.ca2Hs   = 1'b1;
		n.cb2Hs   = 1'b1;
		n.ifr     = '0;
		n.ier     = '0;
	end else if (s.clkEn) begin
		sel    = s.cs1 & ~s.nCs2;
		wr     = sel & ~s.rnw;
		rd     = sel & s.rnw;
		rise   = model.pinQ & ~model.prevQ;
		fall   = ~model.pinQ & model.prevQ;
		pol    = {model.pcr[6], model.pcr[4], model.pcr[2], model.pcr[0]};
		act    = (rise[3:0] & pol) | (fall[3:0] & ~pol);
		t1Load = wr && s.rs == regT1ch;
		t2Load = wr && s.rs == regT2ch;
		setF   = '0;
		clrF   = '0;
		n.prevQ = model.pinQ;
		if (wr) begin
			case (s.rs)
				regOrb:           n.orb = s.dataIn;
				regOra, regOraNh: n.ora = s.dataIn;
				regDdrb:          n.ddrb = s.dataIn;
				regDdra:          n.ddra = s.dataIn;
				regT1cl, regT1ll: n.t1Lat[7:0] = s.dataIn;
				regT1ch, regT1lh: n.t1Lat[15:8] = s.dataIn;
				regT2cl:          n.t2LatLo = s.dataIn;
				regAcr:           n.acr = s.dataIn;
				regPcr:           n.pcr = s.dataIn;
				regIfr:           clrF = s.dataIn[6:0];
				regIer: n.ier = s.dataIn[7] ? (model.ier | s.dataIn[6:0]) :
					(model.ier & ~s.dataIn[6:0]);
				default: ;
			endcase
		end
		// Timer 1 reaches zero, then reloads on the following enable
		if (t1Load) begin
			n.t1Cnt = {s.dataIn, model.t1Lat[7:0]};
			n.t1Armed = 1'b1;
			n.pb7 = 1'b0;
			clrF[flagT1] = 1'b1;
		end else if (model.t1Cnt == 16'h0000) begin
			n.t1Cnt = model.t1Lat;
			n.t1Armed = 1'b0;
			setF[flagT1] = model.acr[6] | model.t1Armed;
			if (model.acr[6]) begin
				n.pb7 = ~model.pb7;
			end else if (model.t1Armed) begin
				n.pb7 = 1'b1;
			end
		end else begin
			n.t1Cnt = model.t1Cnt - 16'd1;
		end
		// Timer 2 steps per enable, or per PB6 fall in pulse mode
		if (t2Load) begin
			n.t2Cnt = {s.dataIn, model.t2LatLo};
			n.t2Armed = 1'b1;
			clrF[flagT2] = 1'b1;
		end else if (!model.acr[5] || fall[4]) begin
			setF[flagT2] = model.t2Armed && model.t2Cnt == 16'h0000;
			n.t2Armed = model.t2Armed && model.t2Cnt != 16'h0000;
			n.t2Cnt = model.t2Cnt - 16'd1;
		end
		if (rd && s.rs == regT1cl) begin
			clrF[flagT1] = 1'b1;
		end
		if (rd && s.rs == regT2cl) begin
			clrF[flagT2] = 1'b1;
		end
		if (sel && s.rs == regOra) begin
			clrF[flagCa1] = 1'b1;
			clrF[flagCa2] = model.pcr[3] | ~model.pcr[1];
		end
		if (sel && s.rs == regOrb) begin
			clrF[flagCb1] = 1'b1;
			clrF[flagCb2] = model.pcr[7] | ~model.pcr[5];
		end
		n.ca2Hs = handshakeLevel(model.ca2Hs, model.pcr[3:1], sel && s.rs == regOra, act[0]);
		n.cb2Hs = handshakeLevel(model.cb2Hs, model.pcr[7:5], sel && s.rs == regOrb, act[2]);
		setF[flagCa1] = act[0];
		setF[flagCa2] = act[1] & ~model.pcr[3];
		setF[flagCb1] = act[2];
		setF[flagCb2] = act[3] & ~model.pcr[7];
		// New sets land only while the flag is clear or the chip is unselected
		for (int i = 0; i < 7; i++) begin
			if (setF[i] && (!model.ifr[i] || !sel)) begin
				n.ifr[i] = 1'b1;
			end else if (clrF[i]) begin
				n.ifr[i] = 1'b0;
			end
		end
	end
	model = n;
endtask

function automatic viaOut_t predictOutputs(input stim_t s);
	viaOut_t  o;
	viaByte_t pbOut;
	logic     irq;
	pbOut = model.orb;
	if (model.acr[7]) begin
		pbOut[7] = model.pb7;
	end
	irq = |(model.ifr & model.ier);
	o.paPins.outVal = model.ora;
	o.paPins.oe     = model.ddra;
	o.pbPins.outVal = pbOut;
	o.pbPins.oe     = model.ddrb;
	o.ca2Oe  = model.pcr[3];
	o.ca2Out = model.pcr[2] ? model.pcr[1] : model.ca2Hs;
	o.cb2Oe  = model.pcr[7];
	o.cb2Out = model.pcr[6] ? model.pcr[5] : model.cb2Hs;
	o.nIrq   = ~irq;
	o.dataOe = s.cs1 & ~s.nCs2 & s.rnw;
	case (s.rs)
		regOrb:           o.dataOut = portRead(pbOut, model.ddrb, s.pbIn);
		regOra, regOraNh: o.dataOut = portRead(model.ora, model.ddra, s.paIn);
		regDdrb:          o.dataOut = model.ddrb;
		regDdra:          o.dataOut = model.ddra;
		regT1cl:          o.dataOut = model.t1Cnt[7:0];
		regT1ch:          o.dataOut = model.t1Cnt[15:8];
		regT1ll:          o.dataOut = model.t1Lat[7:0];
		regT1lh:          o.dataOut = model.t1Lat[15:8];
		regT2cl:          o.dataOut = model.t2Cnt[7:0];
		regT2ch:          o.dataOut = model.t2Cnt[15:8];
		regAcr:           o.dataOut = model.acr;
		regPcr:           o.dataOut = model.pcr;
		regIfr:           o.dataOut = {irq, model.ifr};
		regIer:           o.dataOut = {1'b1, model.ier};
		default:          o.dataOut = 8'h00;
	endcase
	return o;
endfunction

`endif

/* bench/tbVia.sv */
/*
	Testbench for the 6522-style interface adapter.
	Drives random bus traffic, pin activity and timer programs into dut0 on
	the falling clock edge and compares every output with the cycle model
	at each falling edge.
*/

`timescale 1ns/1ps

module tbVia;

	import viaPkg::*;

	`include "viaModel.svh"

	localparam logic [15:0] portMask = (16'd1 << regOra) | (16'd1 << regOrb) |
		(16'd1 << regDdra) | (16'd1 << regDdrb) | (16'd1 << regOraNh) | (16'd1 << regAcr);
	localparam logic [15:0] edgeMask = (16'd1 << regOra) | (16'd1 << regOrb) |
		(16'd1 << regIfr) | (16'd1 << regIer) | (16'd1 << regOraNh);
	localparam logic [15:0] hsMask = (16'd1 << regOra) | (16'd1 << regOrb) |
		(16'd1 << regOraNh) | (16'd1 << regIfr) | (16'd1 << regDdra);

	logic       clk = 1'b0;
	logic       nRESET;
	stim_t      stim;
	logic       wiggle;
	integer     seed;
	viaByte_t   dataOut;
	logic       dataOe;
	pinBus_t    paPins;
	pinBus_t    pbPins;
	logic       ca2Out;
	logic       ca2Oe;
	logic       cb2Out;
	logic       cb2Oe;
	logic       nIrq;
	regAddr_e   backRegs [7] = '{regDdra, regDdrb, regAcr, regPcr, regT1ll, regT1lh, regIer};

	via6522 dut0 (
		.clk(clk), .nRESET(nRESET), .clkEn(stim.clkEn), .cs1(stim.cs1), .nCs2(stim.nCs2),
		.rnw(stim.rnw), .rs(stim.rs), .dataIn(stim.dataIn), .dataOut(dataOut),
		.dataOe(dataOe), .paIn(stim.paIn), .pbIn(stim.pbIn), .paPins(paPins),
		.pbPins(pbPins), .ca1(stim.ca1), .ca2In(stim.ca2In), .cb1In(stim.cb1In),
		.cb2In(stim.cb2In), .ca2Out(ca2Out), .ca2Oe(ca2Oe), .cb2Out(cb2Out),
		.cb2Oe(cb2Oe), .nIrq(nIrq)
	);

	initial begin
		forever begin
			#50 clk = ~clk;
		end
	end

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic reportMismatch(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		abortRun($sformatf("Mismatch at %0t: %s DUT=%h model=%h", $time, name, got, exp));
	endtask

	task automatic checkOutputs();
		viaOut_t e;
		e = predictOutputs(stim);
		assert (nIrq === e.nIrq) else reportMismatch("nIrq", nIrq, e.nIrq);
		assert (dataOe === e.dataOe) else reportMismatch("dataOe", dataOe, e.dataOe);
		assert (!e.dataOe || dataOut === e.dataOut)
			else reportMismatch("dataOut", dataOut, e.dataOut);
		assert (paPins === e.paPins) else reportMismatch("paPins", paPins, e.paPins);
		assert (pbPins === e.pbPins) else reportMismatch("pbPins", pbPins, e.pbPins);
		assert (ca2Oe === e.ca2Oe) else reportMismatch("ca2Oe", ca2Oe, e.ca2Oe);
		assert (cb2Oe === e.cb2Oe) else reportMismatch("cb2Oe", cb2Oe, e.cb2Oe);
		// Undriven CA2/CB2 values carry no meaning
		assert (!e.ca2Oe || ca2Out === e.ca2Out)
			else reportMismatch("ca2Out", ca2Out, e.ca2Out);
		assert (!e.cb2Oe || cb2Out === e.cb2Out)
			else reportMismatch("cb2Out", cb2Out, e.cb2Out);
	endtask

	// Advance past one rising edge, check, then drive the next inputs
	task automatic nextCycle();
		logic [31:0] r;
		@(negedge clk);
		modelStep(!nRESET, stim);
		checkOutputs();
		r = $random(seed);
		stim.clkEn = (r[1:0] != 2'b00);
		if (wiggle) begin
			stim.paIn  = r[15:8];
			stim.pbIn  = r[23:16];
			stim.ca1   = stim.ca1 ^ (r[25:24] == 2'b00);
			stim.ca2In = stim.ca2In ^ (r[27:26] == 2'b00);
			stim.cb1In = stim.cb1In ^ (r[29:28] == 2'b00);
			stim.cb2In = stim.cb2In ^ (r[31:30] == 2'b00);
		end
	endtask

	task automatic idleCycles(input int count);
		repeat (count) nextCycle();
	endtask

	// Holds the transfer until an enabled cycle has taken it
	task automatic busAccess(input logic read, input regSel_t r, input viaByte_t d);
		logic taken;
		int   guard;
		stim.cs1    = 1'b1;
		stim.nCs2   = 1'b0;
		stim.rnw    = read;
		stim.rs     = r;
		stim.dataIn = d;
		taken = 1'b0;
		guard = 0;
		while (!taken && guard < 64) begin
			taken = stim.clkEn;
			nextCycle();
			guard++;
		end
		if (!taken) begin
			abortRun("Bus transfer timed out waiting for an enabled cycle");
		end
		stim.cs1 = 1'b0;
		stim.rnw = 1'b1;
	endtask

	task automatic randomAccess(input logic [15:0] mask, input int count);
		logic [31:0] r;
		regSel_t     target;
		int          k;
		int          j;
		for (k = 0; k < count; k++) begin
			r = $random(seed);
			target = r[3:0];
			for (j = 0; j < 16 && !mask[target]; j++) begin
				target = target + 4'd1;
			end
			busAccess(r[4], target, r[15:8]);
			if (r[5]) begin
				nextCycle();
			end
		end
	endtask

	task automatic waitForIrq(input int limit);
		int n;
		n = 0;
		while (nIrq !== 1'b0 && n < limit) begin
			nextCycle();
			n++;
		end
		if (nIrq !== 1'b0) begin
			abortRun("Timeout waiting for nIrq to go low");
		end
	endtask

	initial begin
		logic [31:0] r;
		int          k;
		seed   = 32'haef74ac2;
		nRESET = 1'b0;
		wiggle = 1'b0;
		stim   = '0;
		stim.nCs2 = 1'b1;
		stim.rnw  = 1'b1;
		idleCycles(8);
		nRESET = 1'b1;
		idleCycles(4);

		// Register write and read-back
		for (k = 0; k < 60; k++) begin
			r = $random(seed);
			busAccess(1'b0, backRegs[r[7:0] % 7], r[15:8]);
			busAccess(1'b1, backRegs[r[7:0] % 7], 8'h00);
		end

		// Port outputs, enables and pin mixing
		wiggle = 1'b1;
		randomAccess(portMask, 120);

		// Timer 1 in one-shot and free-run modes with PB7 output
		wiggle = 1'b0;
		for (k = 0; k < 6; k++) begin
			r = $random(seed);
			busAccess(1'b0, regIer, 8'h7f);
			busAccess(1'b0, regAcr, {1'b1, r[0], 6'b000000});
			busAccess(1'b0, regT1ll, 8'd4 + r[7:4]);
			busAccess(1'b0, regT1ch, 8'h00);
			busAccess(1'b0, regIer, 8'hc0);
			waitForIrq(400);
			busAccess(1'b1, regT1cl, 8'h00);
			idleCycles(40);
		end

		// Timer 2 in one-shot and PB6 pulse counting modes
		for (k = 0; k < 6; k++) begin
			r = $random(seed);
			wiggle = r[0];
			busAccess(1'b0, regIer, 8'h7f);
			busAccess(1'b0, regAcr, {2'b00, r[0], 5'b00000});
			busAccess(1'b0, regT2cl, 8'd2 + r[7:4]);
			busAccess(1'b0, regT2ch, 8'h00);
			busAccess(1'b0, regIer, 8'ha0);
			waitForIrq(2000);
			busAccess(1'b1, regT2cl, 8'h00);
			idleCycles(30);
		end

		// Edge flags with random polarity and masking
		wiggle = 1'b1;
		for (k = 0; k < 4; k++) begin
			r = $random(seed);
			busAccess(1'b0, regPcr, {1'b0, r[6:4], 1'b0, r[2:0]});
			busAccess(1'b0, regIer, {1'b1, r[14:8]});
			busAccess(1'b0, regIer, {1'b0, r[22:16]});
			randomAccess(edgeMask, 50);
		end

		// CA2/CB2 output modes
		for (k = 0; k < 4; k++) begin
			r = $random(seed);
			busAccess(1'b0, regPcr, {1'b1, r[6:4], 1'b1, r[2:0]});
			randomAccess(hsMask, 50);
		end

		idleCycles(10);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+bench
src/viaPkg.sv
src/edgeDetect.sv
src/viaPorts.sv
src/viaTimers.sv
src/viaInterrupts.sv
src/via6522.sv
bench/tbVia.sv
